//--- hw/sharedFifoPkg.sv
// Sizes, vector typedefs and packed structs of the shared-buffer FIFO with push credits.
package sharedFifoPkg;

  // Two logical FIFOs share one flop RAM of eight entries.
  localparam int NumFifos = 2;
  localparam int Depth = 8;
  localparam int Width = 8;

  // Each FIFO has a two-entry staging buffer in front of its pop port.
  localparam int StageDepth = 2;

  // Payload of one word.
  typedef logic [Width-1:0] dataT;

  // Address of one RAM entry.
  typedef logic [$clog2(Depth)-1:0] addrT;

  // Number of a logical FIFO.
  typedef logic [$clog2(NumFifos)-1:0] fifoIdT;

  // Credit or occupancy count, which must be able to hold the full depth.
  typedef logic [$clog2(Depth + 1)-1:0] countT;

  // One bit per logical FIFO.
  typedef logic [NumFifos-1:0] fifoMaskT;

  // A word from the sender, tagged with its FIFO.
  typedef struct packed {
    logic   valid;
    fifoIdT fifoId;
    dataT   data;
  } pushReqT;

  // A write into the shared RAM.
  typedef struct packed {
    logic   valid;
    fifoIdT fifoId;
    addrT   addr;
    dataT   data;
  } ramWriteT;

  // A read request on the single RAM read port.
  typedef struct packed {
    logic   valid;
    fifoIdT fifoId;
    addrT   addr;
  } ramReadReqT;

  // Read data, returned one cycle after the request with the same tag.
  typedef struct packed {
    logic   valid;
    fifoIdT fifoId;
    dataT   data;
  } ramReadRespT;

  // Inclusive base and bound address of every FIFO slice.
  typedef struct packed {
    addrT [NumFifos-1:0] base;
    addrT [NumFifos-1:0] bound;
  } fifoCfgT;

endpackage

//--- hw/sharedFifoPush.sv
// Push side with configuration check, credit counters, credit release and write pointers.
`timescale 1ns/1ps

module sharedFifoPush (
  input  logic                     clk,
  input  logic                     rstN,
  input  sharedFifoPkg::fifoCfgT   cfg,
  input  sharedFifoPkg::pushReqT   push,
  input  sharedFifoPkg::fifoMaskT  pushCreditStall,
  input  sharedFifoPkg::fifoMaskT  popDone,
  output logic                     cfgError,
  output sharedFifoPkg::fifoMaskT  pushCredit,
  output sharedFifoPkg::ramWriteT  ramWrite,
  output sharedFifoPkg::fifoMaskT  pushDone
);

  import sharedFifoPkg::*;

  // Combinational result of the configuration check.
  logic cfgBad;

  // Number of entries in each slice, bound minus base plus one.
  countT [NumFifos-1:0] sliceSize;

  // Credits that the receiver still owes the sender, per FIFO.
  countT [NumFifos-1:0] creditCnt;

  // One credit leaves per FIFO in this cycle.
  fifoMaskT creditRelease;

  // Next RAM address to be written, per FIFO.
  addrT [NumFifos-1:0] wrPtr;

  // Every address lies inside the RAM by its width.
  // A slice is illegal if its base is above its bound.
  // Slices must also be in ascending order without overlap.
  always_comb begin
    cfgBad = 1'b0;
    for (int i = 0; i < NumFifos; i++) begin
      if (cfg.base[i] > cfg.bound[i]) begin
        cfgBad = 1'b1;
      end
    end
    for (int i = 1; i < NumFifos; i++) begin
      if (cfg.base[i] <= cfg.bound[i-1]) begin
        cfgBad = 1'b1;
      end
    end
  end

  // The check result is registered and already valid in the first cycle after reset.
  always_ff @(posedge clk) begin
    cfgError <= cfgBad;
  end

  // The full credit pool of each FIFO is its slice size.
  always_comb begin
    for (int i = 0; i < NumFifos; i++) begin
      sliceSize[i] = countT'(cfg.bound[i]) - countT'(cfg.base[i]) + countT'(1);
    end
  end

  // A credit goes out while the counter holds one and the sender does not stall.
  // No credit ever leaves under a bad configuration.
  always_comb begin
    for (int i = 0; i < NumFifos; i++) begin
      creditRelease[i] = (creditCnt[i] != '0) && !pushCreditStall[i] && !cfgError;
    end
  end

  // The counter starts with the whole pool.
  // Each released credit takes one away and each pop gives one back.
  // The credit pulse itself is registered, so the first one shows on the second cycle.
  always_ff @(posedge clk) begin
    if (!rstN) begin
      creditCnt  <= sliceSize;
      pushCredit <= '0;
    end else begin
      for (int i = 0; i < NumFifos; i++) begin
        creditCnt[i] <= creditCnt[i] - countT'(creditRelease[i]) + countT'(popDone[i]);
      end
      pushCredit <= creditRelease;
    end
  end

  // Every push becomes a RAM write in the same cycle.
  // The address comes from the registered pointer of the tagged FIFO.
  always_comb begin
    ramWrite.valid  = push.valid && !cfgError;
    ramWrite.fifoId = push.fifoId;
    ramWrite.addr   = wrPtr[push.fifoId];
    ramWrite.data   = push.data;
  end

  // The pop side counts these pulses as RAM occupancy.
  always_comb begin
    for (int i = 0; i < NumFifos; i++) begin
      pushDone[i] = ramWrite.valid && (ramWrite.fifoId == fifoIdT'(i));
    end
  end

  // Write pointers walk through the slice and wrap from bound back to base.
  always_ff @(posedge clk) begin
    if (!rstN) begin
      wrPtr <= cfg.base;
    end else begin
      for (int i = 0; i < NumFifos; i++) begin
        if (pushDone[i]) begin
          wrPtr[i] <= (wrPtr[i] == cfg.bound[i]) ? cfg.base[i] : addrT'(wrPtr[i] + 3'd1);
        end
      end
    end
  end

endmodule

//--- hw/sharedFifoRam.sv
// Eight-entry flop RAM with one write port and a registered, tagged read port.
`timescale 1ns/1ps

module sharedFifoRam (
  input  logic                        clk,
  input  sharedFifoPkg::ramWriteT     ramWrite,
  input  sharedFifoPkg::ramReadReqT   ramReadReq,
  output sharedFifoPkg::ramReadRespT  ramReadResp
);

  import sharedFifoPkg::*;

  // Storage shared by all slices.
  dataT mem [Depth];

  // Writes land at the end of the push cycle.
  always_ff @(posedge clk) begin
    if (ramWrite.valid) begin
      mem[ramWrite.addr] <= ramWrite.data;
    end
  end

  // The read is one cycle deep.
  // Valid and FIFO id travel with the data so the pop side knows where it goes.
  // A read never hits an entry that is written in the same cycle,
  // because the scheduler only reads entries that were counted before.
  always_ff @(posedge clk) begin
    ramReadResp.valid  <= ramReadReq.valid;
    ramReadResp.fifoId <= ramReadReq.fifoId;
    ramReadResp.data   <= mem[ramReadReq.addr];
  end

endmodule

//--- hw/sharedFifoPop.sv
// Pop side with read pointers, occupancy, round-robin read scheduler and staging buffers.
`timescale 1ns/1ps

module sharedFifoPop (
  input  logic                                               clk,
  input  logic                                               rstN,
  input  sharedFifoPkg::fifoCfgT                             cfg,
  input  sharedFifoPkg::fifoMaskT                            pushDone,
  input  sharedFifoPkg::ramReadRespT                         ramReadResp,
  input  sharedFifoPkg::fifoMaskT                            popReady,
  output sharedFifoPkg::ramReadReqT                          ramReadReq,
  output sharedFifoPkg::fifoMaskT                            popValid,
  output sharedFifoPkg::dataT [sharedFifoPkg::NumFifos-1:0]  popData,
  output sharedFifoPkg::fifoMaskT                            popEmpty,
  output sharedFifoPkg::fifoMaskT                            popDone
);

  import sharedFifoPkg::*;

  // Words written to the RAM and not yet read, per FIFO.
  countT [NumFifos-1:0] ramCnt;
  // Reads issued whose data has not yet arrived.
  countT [NumFifos-1:0] inFlight;
  // Words held in each staging buffer.
  countT [NumFifos-1:0] stageCnt;
  // Slot that the arriving word takes after a pop in the same cycle.
  countT [NumFifos-1:0] stageSlot;
  // Staging storage, entry 0 is the head.
  dataT [NumFifos-1:0][StageDepth-1:0] stageData;
  // Next RAM address to read, per FIFO.
  addrT [NumFifos-1:0] rdPtr;

  fifoMaskT eligible;
  fifoMaskT grant;
  fifoMaskT stageWrite;
  fifoIdT   grantId;
  fifoIdT   lastId;

  // The head of each staging buffer drives its pop port.
  always_comb begin
    for (int i = 0; i < NumFifos; i++) begin
      popValid[i]   = (stageCnt[i] != '0);
      popData[i]    = stageData[i][0];
      popDone[i]    = popValid[i] && popReady[i];
      stageWrite[i] = ramReadResp.valid && (ramReadResp.fifoId == fifoIdT'(i));
      stageSlot[i]  = stageCnt[i] - countT'(popDone[i]);
      popEmpty[i]   = (ramCnt[i] == '0) && (inFlight[i] == '0) && (stageCnt[i] == '0);
    end
  end

  // A FIFO may be read when the RAM holds a word for it and its staging buffer
  // has room for that word, counting reads still in flight.
  // A pop in this cycle frees one slot.
  always_comb begin
    for (int i = 0; i < NumFifos; i++) begin
      eligible[i] = (ramCnt[i] != '0) &&
                    ((stageCnt[i] + inFlight[i] < countT'(StageDepth)) || popDone[i]);
    end
  end

  // Round robin, the search starts just after the FIFO granted last.
  always_comb begin
    fifoIdT cand;
    logic   found;
    found   = 1'b0;
    grantId = lastId;
    grant   = '0;
    for (int k = 1; k <= NumFifos; k++) begin
      cand = fifoIdT'((int'(lastId) + k) % NumFifos);
      if (!found && eligible[cand]) begin
        found   = 1'b1;
        grantId = cand;
      end
    end
    if (found) begin
      grant[grantId] = 1'b1;
    end
  end

  // One read request per cycle on the single RAM read port.
  always_comb begin
    ramReadReq.valid  = |grant;
    ramReadReq.fifoId = grantId;
    ramReadReq.addr   = rdPtr[grantId];
  end

  // Counters and read pointers.
  always_ff @(posedge clk) begin
    if (!rstN) begin
      ramCnt   <= '0;
      inFlight <= '0;
      stageCnt <= '0;
      rdPtr    <= cfg.base;
      lastId   <= fifoIdT'(NumFifos - 1);
    end else begin
      for (int i = 0; i < NumFifos; i++) begin
        ramCnt[i]   <= ramCnt[i] + countT'(pushDone[i]) - countT'(grant[i]);
        inFlight[i] <= inFlight[i] + countT'(grant[i]) - countT'(stageWrite[i]);
        stageCnt[i] <= stageCnt[i] + countT'(stageWrite[i]) - countT'(popDone[i]);
        if (grant[i]) begin
          rdPtr[i] <= (rdPtr[i] == cfg.bound[i]) ? cfg.base[i] : addrT'(rdPtr[i] + 3'd1);
        end
      end
      if (|grant) begin
        lastId <= grantId;
      end
    end
  end

  // A pop shifts the buffer toward the head.
  // The arriving word goes behind the last word that stays.
  always_ff @(posedge clk) begin
    for (int i = 0; i < NumFifos; i++) begin
      if (popDone[i]) begin
        for (int j = 0; j < StageDepth - 1; j++) begin
          stageData[i][j] <= stageData[i][j+1];
        end
      end
      if (stageWrite[i]) begin
        stageData[i][stageSlot[i]] <= ramReadResp.data;
      end
    end
  end

endmodule

//--- hw/sharedFifoTop.sv
// Top level of the shared-buffer FIFO, connecting push side, RAM and pop side.
`timescale 1ns/1ps

module sharedFifoTop (
  input  logic                                               clk,
  input  logic                                               rstN,

  // Slices are set before reset is released and held stable afterwards.
  input  sharedFifoPkg::fifoCfgT                             cfg,
  output logic                                               cfgError,

  // Push side with credit flow control.
  input  sharedFifoPkg::pushReqT                             push,
  output sharedFifoPkg::fifoMaskT                            pushCredit,
  input  sharedFifoPkg::fifoMaskT                            pushCreditStall,

  // One valid/ready pop port per FIFO.
  input  sharedFifoPkg::fifoMaskT                            popReady,
  output sharedFifoPkg::fifoMaskT                            popValid,
  output sharedFifoPkg::dataT [sharedFifoPkg::NumFifos-1:0]  popData,
  output sharedFifoPkg::fifoMaskT                            popEmpty
);

  import sharedFifoPkg::*;

  ramWriteT    ramWrite;
  ramReadReqT  ramReadReq;
  ramReadRespT ramReadResp;

  // Accepted writes, counted as occupancy on the pop side.
  fifoMaskT pushDone;
  // Pop handshakes, each of which returns one credit.
  fifoMaskT popDone;

  sharedFifoPush pushSide (
    .clk,
    .rstN,
    .cfg,
    .push,
    .pushCreditStall,
    .popDone,
    .cfgError,
    .pushCredit,
    .ramWrite,
    .pushDone
  );

  sharedFifoRam ram (
    .clk,
    .ramWrite,
    .ramReadReq,
    .ramReadResp
  );

  sharedFifoPop popSide (
    .clk,
    .rstN,
    .cfg,
    .pushDone,
    .ramReadResp,
    .popReady,
    .ramReadReq,
    .popValid,
    .popData,
    .popEmpty,
    .popDone
  );

endmodule

//--- sim/tbClockGen.sv
// Testbench clock generator with a 100 ns period.
`timescale 1ns/1ps

module tbClockGen (
  output logic clk
);

  // Half a period of 50 ns gives the 100 ns clock.
  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

endmodule

//--- sim/sharedFifoTb.sv
// Testbench with data file reader, credit-counting sender model, pop checks and timeout.
`timescale 1ns/1ps

module sharedFifoTb;

  import sharedFifoPkg::*;

  // One test block from the data file, with the range of its push lines.
  typedef struct packed {
    fifoCfgT                  cfg;
    logic                     cfgError;
    countT [NumFifos-1:0]     credits;
    logic [NumFifos-1:0][7:0] holdCycles;
    fifoIdT                   stallFifo;
    logic [7:0]               stallStart;
    logic [7:0]               stallLen;
    logic [15:0]              firstPush;
    logic [15:0]              numPushes;
  } blockT;

  logic                clk;
  logic                rstN;
  fifoCfgT             cfg;
  logic                cfgError;
  pushReqT             push;
  fifoMaskT            pushCredit;
  fifoMaskT            pushCreditStall;
  fifoMaskT            popReady;
  fifoMaskT            popValid;
  dataT [NumFifos-1:0] popData;
  fifoMaskT            popEmpty;

  blockT   blocks[$];
  pushReqT pushList[$];
  // Expected pop data in push order, one queue per FIFO.
  dataT    expQ0[$];
  dataT    expQ1[$];

  // Sender model: credits held and received, words in the DUT, pops seen.
  int       held [NumFifos];
  int       recv [NumFifos];
  int       occ  [NumFifos];
  int       pops [NumFifos];
  // Stall of the previous cycle, which governs the credit pulses of this one.
  fifoMaskT stallPrev;
  int       nextPush;
  int       dataErrors;
  int       countErrors;
  int       flagErrors;
  int       otherErrors;
  int       cycleLimit;
  int       cycleCount;

  tbClockGen clockGen (.clk(clk));

  sharedFifoTop UUT (.clk, .rstN, .cfg, .cfgError, .push, .pushCredit, .pushCreditStall,
                     .popReady, .popValid, .popData, .popEmpty);

  task automatic checkData(input string name, input dataT got, input dataT exp);
    if (got !== exp) begin
      dataErrors++;
      $display("** Error %s: got %h, expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic checkCount(input string name, input countT got, input countT exp);
    if (got !== exp) begin
      countErrors++;
      $display("** Error %s: got %h, expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic checkFlag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      flagErrors++;
      $display("** Error %s: got %h, expected %h at %0t", name, got, exp, $time);
    end
  endtask

  // Lines start with a keyword; a lone # starts a comment that runs to the end of the line.
  task automatic readTestData();
    int          fd;
    int          n;
    int          f [12];
    logic [63:0] word;
    logic [8*160-1:0] rest;
    blockT       cur;
    bit          reading;
    fd = $fopen("sim/sharedFifo_testdata.txt", "r");
    if (fd == 0) begin
      otherErrors++;
      $display("Could not open the test data file.");
    end else begin
      cur = '0;
      reading = 1'b1;
      while (reading) begin
        word = '0;
        n = $fscanf(fd, "%s", word);
        if (n != 1) begin
          reading = 1'b0;
        end else if (word == "#") begin
          n = $fgets(rest, fd);
        end else if (word == "block") begin
          n = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h", f[0], f[1], f[2], f[3],
                      f[4], f[5], f[6], f[7], f[8], f[9], f[10], f[11]);
          if (n != 12) begin
            otherErrors++;
            $display("A block line of the test data file is incomplete.");
          end
          cur.cfg.base[0]  = addrT'(f[0]);
          cur.cfg.bound[0] = addrT'(f[1]);
          cur.cfg.base[1]  = addrT'(f[2]);
          cur.cfg.bound[1] = addrT'(f[3]);
          cur.cfgError     = f[4][0];
          cur.credits      = {countT'(f[6]), countT'(f[5])};
          cur.holdCycles   = {8'(f[8]), 8'(f[7])};
          cur.stallFifo    = fifoIdT'(f[9]);
          cur.stallStart   = 8'(f[10]);
          cur.stallLen     = 8'(f[11]);
          cur.firstPush    = 16'(pushList.size());
          cur.numPushes    = '0;
        end else if (word == "push") begin
          n = $fscanf(fd, "%h %h", f[0], f[1]);
          pushList.push_back({1'b1, fifoIdT'(f[0]), dataT'(f[1])});
          cur.numPushes++;
        end else if (word == "end") begin
          blocks.push_back(cur);
        end else begin
          otherErrors++;
          $display("The test data file holds an unknown keyword.");
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic driveIdle();
    push = '0;
    pushCreditStall = '0;
    popReady = '0;
  endtask

  // Stall window and ready gaps for this cycle; the sender pushes in file order when it has credit.
  task automatic driveInputs(input blockT blk, input int cyc, input int lastPush);
    fifoIdT id;
    stallPrev = pushCreditStall;
    for (int i = 0; i < NumFifos; i++) begin
      pushCreditStall[i] = (fifoIdT'(i) == blk.stallFifo) && (cyc >= int'(blk.stallStart)) &&
                           (cyc < int'(blk.stallStart) + int'(blk.stallLen));
      popReady[i] = (cyc >= int'(blk.holdCycles[i])) && (($urandom % 4) != 0);
    end
    push = '0;
    if (nextPush < lastPush) begin
      id = pushList[nextPush].fifoId;
      if (held[id] > 0) begin
        push = pushList[nextPush];
        held[id]--;
        occ[id]++;
        if (id == 0) expQ0.push_back(push.data);
        else expQ1.push_back(push.data);
        nextPush++;
      end
    end
  endtask

  // Runs mid-cycle, where the DUT outputs and the driven inputs are settled.
  task automatic sampleOutputs(input blockT blk);
    dataT exp;
    int   size;
    for (int i = 0; i < NumFifos; i++) begin
      if (pushCredit[i]) begin
        recv[i]++;
        held[i]++;
      end
      if (stallPrev[i]) begin
        checkFlag($sformatf("pushCredit[%0d] after stall", i), pushCredit[i], 1'b0);
      end
      // A word waiting at the pop port means the FIFO is not empty.
      if (popValid[i]) begin
        checkFlag($sformatf("popEmpty[%0d]", i), popEmpty[i], 1'b0);
      end
      // Credits held plus words inside may never exceed the slice.
      if (held[i] + occ[i] > int'(blk.credits[i])) begin
        otherErrors++;
        $display("FIFO %0d has more credits and words out than its slice at %0t", i, $time);
      end
      if (popValid[i] && popReady[i]) begin
        size = (i == 0) ? expQ0.size() : expQ1.size();
        if (size == 0) begin
          otherErrors++;
          $display("FIFO %0d popped a word that was never pushed at %0t", i, $time);
        end else begin
          exp = (i == 0) ? expQ0.pop_front() : expQ1.pop_front();
          checkData($sformatf("popData[%0d]", i), popData[i], exp);
          occ[i]--;
          pops[i]++;
        end
      end
    end
  endtask

  task automatic runBlock(input blockT blk);
    int lastPush;
    int cyc;
    bit finished;
    @(posedge clk);
    #5;
    rstN = 1'b0;
    cfg = blk.cfg;
    driveIdle();
    stallPrev = '0;
    for (int i = 0; i < NumFifos; i++) begin
      held[i] = 0;
      recv[i] = 0;
      occ[i] = 0;
      pops[i] = 0;
    end
    expQ0.delete();
    expQ1.delete();
    nextPush = blk.firstPush;
    lastPush = int'(blk.firstPush) + int'(blk.numPushes);
    repeat (8) @(posedge clk);
    #5;
    rstN = 1'b1;
    // Credits come one per cycle from the second cycle on, as many as the slice holds.
    for (int c = 0; c < Depth + 2; c++) begin
      @(negedge clk);
      if (c == 0) checkFlag("cfgError", cfgError, blk.cfgError);
      for (int i = 0; i < NumFifos; i++) begin
        if (c == 0) checkFlag($sformatf("popValid[%0d]", i), popValid[i], 1'b0);
        checkFlag($sformatf("pushCredit[%0d]", i), pushCredit[i],
                  (c >= 1) && (c <= int'(blk.credits[i])));
        recv[i] += int'(pushCredit[i]);
      end
    end
    for (int i = 0; i < NumFifos; i++) begin
      held[i] = recv[i];
      checkCount($sformatf("pushCredit[%0d] initial count", i), countT'(recv[i]),
                 blk.credits[i]);
    end
    // Push and pop until every word is out and every credit has come back.
    finished = 1'b0;
    cyc = 0;
    while (!finished) begin
      @(posedge clk);
      #5;
      driveInputs(blk, cyc, lastPush);
      @(negedge clk);
      sampleOutputs(blk);
      finished = (nextPush == lastPush) && (expQ0.size() == 0) && (expQ1.size() == 0);
      for (int i = 0; i < NumFifos; i++) begin
        finished &= (recv[i] == int'(blk.credits[i]) + pops[i]);
      end
      cyc++;
    end
    // A few idle cycles show that no stray credits or words remain.
    for (int c = 0; c < 4; c++) begin
      @(posedge clk);
      #5;
      stallPrev = pushCreditStall;
      driveIdle();
      popReady = '1;
      @(negedge clk);
      sampleOutputs(blk);
    end
    checkFlag("cfgError", cfgError, blk.cfgError);
    for (int i = 0; i < NumFifos; i++) begin
      checkFlag($sformatf("popEmpty[%0d]", i), popEmpty[i], 1'b1);
      checkFlag($sformatf("popValid[%0d]", i), popValid[i], 1'b0);
      checkCount($sformatf("pushCredit[%0d] total count", i), countT'(recv[i]),
                 countT'(int'(blk.credits[i]) + pops[i]));
    end
  endtask

  initial begin
    void'($urandom(32'h5bcd));
    rstN = 1'b0;
    cfg = '0;
    driveIdle();
    stallPrev = '0;
    cycleLimit = 0;
    readTestData();
    if (blocks.size() == 0) begin
      otherErrors++;
      $display("The test data file holds no test block.");
    end else begin
      cycleLimit = 20 * pushList.size() + 200 * blocks.size();
      foreach (blocks[b]) runBlock(blocks[b]);
    end
    $display("Errors: data %0d, count %0d, flag %0d, other %0d",
             dataErrors, countErrors, flagErrors, otherErrors);
    if (dataErrors + countErrors + flagErrors + otherErrors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  // Watchdog that stops a run which stalls somewhere.
  initial begin
    cycleCount = 0;
    wait (cycleLimit != 0);
    while (cycleCount < cycleLimit) begin
      @(posedge clk);
      cycleCount++;
    end
    $display("The run timed out after %0d cycles before all blocks were done.", cycleCount);
    $display("Errors: data %0d, count %0d, flag %0d, other %0d",
             dataErrors, countErrors, flagErrors, otherErrors);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

//--- sim/sharedFifo_testdata.txt
# block: base0 bound0 base1 bound1 cfgError credits0 credits1 hold0 hold1 stallFifo stallStart stallLen
# push: fifoId data; all fields in hex; end closes a block
block 0 3 4 7 0 4 4 0 0 1 3 8
push 0 11
push 1 21
push 0 12
push 1 22
push 0 13
push 0 14
push 1 23
push 1 24
push 0 15
push 1 25
end
block 0 4 5 7 0 5 3 28 0 0 2 6
push 0 a1
push 0 a2
push 0 a3
push 0 a4
push 1 b1
push 1 b2
push 1 b3
push 1 b4
push 1 b5
push 0 a5
push 0 a6
end
block 3 2 4 7 1 0 0 0 0 0 0 0
end
block 0 4 3 7 1 0 0 0 0 0 0 0
end
block 4 7 0 3 1 0 0 0 0 0 0 0
end

//--- flist.f
hw/sharedFifoPkg.sv
hw/sharedFifoPush.sv
hw/sharedFifoRam.sv
hw/sharedFifoPop.sv
hw/sharedFifoTop.sv
sim/tbClockGen.sv
sim/sharedFifoTb.sv

//--- Bender.yml
package:
  name: shared_fifo

sources:
  - files:
      - hw/sharedFifoPkg.sv
      - hw/sharedFifoPush.sv
      - hw/sharedFifoRam.sv
      - hw/sharedFifoPop.sv
      - hw/sharedFifoTop.sv
  - target: simulation
    files:
      - sim/tbClockGen.sv
      - sim/sharedFifoTb.sv
